// File: writeback_top.f
+incdir+tb
logic/writeback_pkg.sv
logic/wb_commit_ctrl.sv
logic/stack_commit.sv
logic/gpr_file.sv
logic/writeback_top.sv
tb/writeback_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module writeback_tb \
   -f writeback_top.f \
   -o writeback_sim

sim_out="$(./obj_dir/writeback_sim 2>&1 || true)"
echo "$sim_out"

if grep -q "TB PASSED" <<< "$sim_out"; then
   echo "simulation passed"
   exit 0
fi

echo "simulation failed"
exit 1

// File: tb/wb_model.svh
`ifndef WB_MODEL_SVH
`define WB_MODEL_SVH

// register file image, stepped at each rising edge
gpr_t m_gpr [NUM_GPR];

function automatic gpr_t size_mask(op_size_t size);
   case (size)
      SIZE_BYTE: return 32'h0000_00ff;
      SIZE_WORD: return 32'h0000_ffff;
      default:   return 32'hffff_ffff;
   endcase
endfunction

function automatic gpr_t byte_count(op_size_t size);
   case (size)
      SIZE_BYTE: return 32'd1;
      SIZE_WORD: return 32'd2;
      default:   return 32'd4;
   endcase
endfunction

function automatic logic is_xchg_to_mem(wb_bundle_t b);
   return (b.alu_op == ALU_OP_XCHG) && b.op_b_is_address;
endfunction

function automatic logic has_mem_target(wb_bundle_t b);
   return b.op_a_is_address || is_xchg_to_mem(b);
endfunction

// stall on a busy memory or when decode owns port 1
function automatic logic expected_ready(wb_bundle_t b, dec_wb_t d, logic mem_ready);
   if (has_mem_target(b) && !mem_ready) begin
      return 1'b0;
   end
   if (d.valid && b.op_a_is_reg) begin
      return 1'b0;
   end
   return 1'b1;
endfunction

function automatic addr_t expected_addr(wb_bundle_t b);
   if (is_xchg_to_mem(b)) begin
      return b.op_b_address;
   end
   return b.dest_address;
endfunction

function automatic result_t expected_data(wb_bundle_t b);
   if (is_xchg_to_mem(b)) begin
      return {32'h0, b.result[63:32]};
   end
   return b.result;
endfunction

task automatic model_reset();
   for (int i = 0; i < NUM_GPR; i++) begin
      m_gpr[i] = '0;
   end
endtask

task automatic model_write(reg_num_t num, gpr_t data, op_size_t size);
   gpr_t mask;
   mask       = size_mask(size);
   m_gpr[num] = (m_gpr[num] & ~mask) | (data & mask);
endtask

task automatic model_step(wb_bundle_t b, dec_wb_t d, logic accept);
   gpr_t esp_now;
   esp_now = m_gpr[REG_ESP];
   if (d.valid) begin
      model_write(d.reg_num, d.data, d.size);
   end else if (accept && b.op_a_is_reg) begin
      model_write(b.dest_reg, b.result[31:0], b.opsize);
   end
   // second write of an exchange lands last
   if (accept && (b.alu_op == ALU_OP_XCHG) && b.op_b_is_reg) begin
      model_write(b.op_b_reg, b.result[63:32], SIZE_DWORD);
   end
   if (accept && (b.stack_op == STACK_PUSH)) begin
      m_gpr[REG_ESP] = esp_now - byte_count(b.opsize);
   end else if (accept && (b.stack_op == STACK_POP)) begin
      m_gpr[REG_ESP] = esp_now + byte_count(b.opsize);
   end
endtask

`endif

// File: tb/writeback_tb.sv
`timescale 1ns/1ns

module writeback_tb;
   import writeback_pkg::*;

   localparam int STALL_LIMIT = 64;

   logic       clk;
   logic       rst_n;
   wb_bundle_t wb_in;
   logic       wb_valid;
   dec_wb_t    dec_wb;
   logic       wmem_ready;
   logic       wb_ready;
   mem_wr_t    wmem;
   logic       wmem_valid;
   gpr_bank_t  gpr;

   int         checks;
   int         errors;
   logic       timed_out;
   wb_bundle_t item;

   `include "wb_model.svh"

   writeback_top uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .wb_in      (wb_in),
      .wb_valid   (wb_valid),
      .dec_wb     (dec_wb),
      .wmem_ready (wmem_ready),
      .wb_ready   (wb_ready),
      .wmem       (wmem),
      .wmem_valid (wmem_valid),
      .gpr        (gpr)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                              input string what);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      end
   endtask

   task automatic compare_regs();
      for (int i = 0; i < NUM_GPR; i++) begin
         check_value(64'(gpr[i]), 64'(m_gpr[i]), $sformatf("gpr[%0d]", i));
      end
   endtask

   task automatic drive_side(input int dec_pct, input int rdy_pct);
      dec_wb.valid   = int'($urandom_range(0, 99)) < dec_pct;
      dec_wb.reg_num = reg_num_t'($urandom_range(0, 7));
      dec_wb.size    = op_size_t'($urandom_range(0, 2));
      dec_wb.data    = $urandom();
      wmem_ready     = int'($urandom_range(0, 99)) < rdy_pct;
   endtask

   // no targets set, callers pick the kind
   function automatic wb_bundle_t random_bundle();
      wb_bundle_t b;
      b.dest_address    = $urandom();
      b.dest_reg        = reg_num_t'($urandom_range(0, 7));
      b.result          = {$urandom(), $urandom()};
      b.opsize          = op_size_t'($urandom_range(0, 2));
      b.alu_op          = alu_op_t'($urandom_range(0, 13));
      b.op_a_is_address = 1'b0;
      b.op_a_is_reg     = 1'b0;
      b.op_b_reg        = reg_num_t'($urandom_range(0, 7));
      b.op_b_address    = $urandom();
      b.op_b_is_reg     = 1'b0;
      b.op_b_is_address = 1'b0;
      b.stack_op        = STACK_NONE;
      return b;
   endfunction

   task automatic send_item(input wb_bundle_t b, input int dec_pct, input int rdy_pct);
      int   waited;
      logic taken;
      waited = 0;
      taken  = 1'b0;
      while (!taken && !timed_out) begin
         @(negedge clk);
         compare_regs();
         wb_in    = b;
         wb_valid = 1'b1;
         drive_side(dec_pct, rdy_pct);
         @(posedge clk);
         taken = wb_ready;
         waited++;
         if (!taken && waited >= STALL_LIMIT) begin
            $display("timeout: item still not accepted after %0d cycles", waited);
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic idle_cycle(input int dec_pct);
      @(negedge clk);
      compare_regs();
      wb_valid = 1'b0;
      drive_side(dec_pct, 100);
   endtask

   // decode write collides with an op_a register result
   task automatic hold_with_decode(input wb_bundle_t b, input int cycles);
      for (int c = 0; c < cycles; c++) begin
         @(negedge clk);
         compare_regs();
         wb_in    = b;
         wb_valid = 1'b1;
         drive_side(100, 100);
         @(posedge clk);
         check_value(64'(wb_ready), 64'd0, "wb_ready during decode collision");
      end
   endtask

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         model_reset();
      end else begin
         check_value(64'(wb_ready), 64'(expected_ready(wb_in, dec_wb, wmem_ready)),
                     "wb_ready");
         check_value(64'(wmem_valid), 64'(wb_valid && has_mem_target(wb_in)), "wmem_valid");
         if (wmem_valid && wmem_ready) begin
            check_value(64'(wmem.address), 64'(expected_addr(wb_in)), "wmem.address");
            check_value(wmem.data, expected_data(wb_in), "wmem.data");
            check_value(64'(wmem.size), 64'(wb_in.opsize), "wmem.size");
         end
         model_step(wb_in, dec_wb, wb_valid && wb_ready);
      end
   end

   initial begin
      void'($urandom(32'h1d3f197e));
      checks     = 0;
      errors     = 0;
      timed_out  = 1'b0;
      rst_n      = 1'b0;
      wb_valid   = 1'b0;
      wb_in      = '0;
      dec_wb     = '0;
      wmem_ready = 1'b0;
      model_reset();

      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      for (int i = 0; i < NUM_GPR; i++) begin
         check_value(64'(gpr[i]), 64'd0, $sformatf("gpr[%0d] after reset", i));
      end
      check_value(64'(wmem_valid), 64'd0, "wmem_valid after reset");

      // register results of every size
      for (int n = 0; n < 200 && !timed_out; n++) begin
         item             = random_bundle();
         item.op_a_is_reg = 1'b1;
         send_item(item, 30, 100);
         if ($urandom_range(0, 3) == 0) begin
            idle_cycle(30);
         end
      end

      // memory results, plain and exchange
      for (int n = 0; n < 150 && !timed_out; n++) begin
         item = random_bundle();
         if ($urandom_range(0, 1) == 1) begin
            item.alu_op          = ALU_OP_XCHG;
            item.op_b_is_address = 1'b1;
         end else begin
            item.op_a_is_address = 1'b1;
         end
         send_item(item, 20, 60);
      end

      for (int n = 0; n < 80 && !timed_out; n++) begin
         item             = random_bundle();
         item.alu_op      = ALU_OP_XCHG;
         item.op_a_is_reg = 1'b1;
         item.op_b_is_reg = 1'b1;
         if ($urandom_range(0, 1) == 1) begin
            item.op_b_reg = item.dest_reg;
         end
         send_item(item, 20, 100);
      end

      // push and pop, often racing a write to esp
      for (int n = 0; n < 100 && !timed_out; n++) begin
         item             = random_bundle();
         item.stack_op    = ($urandom_range(0, 1) == 1) ? STACK_PUSH : STACK_POP;
         item.op_a_is_reg = 1'($urandom_range(0, 1));
         if ($urandom_range(0, 1) == 1) begin
            item.dest_reg = REG_ESP;
         end
         send_item(item, 20, 100);
      end

      for (int n = 0; n < 20 && !timed_out; n++) begin
         item             = random_bundle();
         item.op_a_is_reg = 1'b1;
         hold_with_decode(item, 1 + int'($urandom_range(0, 3)));
         send_item(item, 0, 100);
      end

      @(negedge clk);
      compare_regs();
      wb_valid     = 1'b0;
      dec_wb.valid = 1'b0;
      @(negedge clk);
      compare_regs();

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
      if (errors == 0 && !timed_out) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: logic/writeback_top.sv
`timescale 1ns/1ns

module writeback_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  writeback_pkg::wb_bundle_t wb_in,
   input  logic                      wb_valid,
   input  writeback_pkg::dec_wb_t    dec_wb,
   input  logic                      wmem_ready,
   output logic                      wb_ready,
   output writeback_pkg::mem_wr_t    wmem,
   output logic                      wmem_valid,
   output writeback_pkg::gpr_bank_t  gpr
);
   import writeback_pkg::*;

   logic    wb_accept;
   reg_wr_t reg_wr_a;
   reg_wr_t reg_wr_b;
   gpr_t    esp_next;
   logic    esp_en;

   wb_commit_ctrl u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .wb_in      (wb_in),
      .wb_valid   (wb_valid),
      .dec_wb     (dec_wb),
      .wmem_ready (wmem_ready),
      .wb_ready   (wb_ready),
      .wmem       (wmem),
      .wmem_valid (wmem_valid),
      .wb_accept  (wb_accept),
      .reg_wr_a   (reg_wr_a),
      .reg_wr_b   (reg_wr_b)
   );

   // esp read back from the register file
   stack_commit u_stack (
      .clk       (clk),
      .rst_n     (rst_n),
      .wb_accept (wb_accept),
      .stack_op  (wb_in.stack_op),
      .opsize    (wb_in.opsize),
      .esp       (gpr[REG_ESP]),
      .esp_next  (esp_next),
      .esp_en    (esp_en)
   );

   gpr_file u_gpr (
      .clk      (clk),
      .rst_n    (rst_n),
      .reg_wr_a (reg_wr_a),
      .reg_wr_b (reg_wr_b),
      .esp_next (esp_next),
      .esp_en   (esp_en),
      .gpr      (gpr)
   );

endmodule

// File: logic/gpr_file.sv
`timescale 1ns/1ns

module gpr_file (
   input  logic                     clk,
   input  logic                     rst_n,
   input  writeback_pkg::reg_wr_t   reg_wr_a,
   input  writeback_pkg::reg_wr_t   reg_wr_b,
   input  writeback_pkg::gpr_t      esp_next,
   input  logic                     esp_en,
   output writeback_pkg::gpr_bank_t gpr
);
   import writeback_pkg::*;

   gpr_bank_t gpr_next;

   // sized write, upper bits keep their old value
   function automatic gpr_t merge_sized(
      input gpr_t     old_val,
      input gpr_t     new_val,
      input op_size_t size
   );
      gpr_t merged;
      merged = old_val;
      case (size)
         SIZE_BYTE: merged[7:0]  = new_val[7:0];
         SIZE_WORD: merged[15:0] = new_val[15:0];
         default:   merged       = new_val;
      endcase
      return merged;
   endfunction

   always_comb begin
      gpr_next = gpr;

      if (reg_wr_a.en) begin
         gpr_next[reg_wr_a.num] = merge_sized(gpr[reg_wr_a.num], reg_wr_a.data,
                                              reg_wr_a.size);
      end

      // port 2 applied last so it wins on the same register
      if (reg_wr_b.en) begin
         gpr_next[reg_wr_b.num] = merge_sized(gpr[reg_wr_b.num], reg_wr_b.data,
                                              reg_wr_b.size);
      end

      // stack adjustment beats any port write to esp
      if (esp_en) begin
         gpr_next[REG_ESP] = esp_next;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gpr <= '0;
      end else begin
         gpr <= gpr_next;
      end
   end

   property p_legal_port_size(logic en, op_size_t size);
      @(posedge clk) disable iff (!rst_n)
         en |-> size_is_legal(size);
   endproperty

   a_legal_size_a : assert property (p_legal_port_size(reg_wr_a.en, reg_wr_a.size))
      else $error("port 1 write with illegal size %0d", reg_wr_a.size);

endmodule

// File: logic/stack_commit.sv
`timescale 1ns/1ns

module stack_commit (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     wb_accept,
   input  writeback_pkg::stack_op_t stack_op,
   input  writeback_pkg::op_size_t  opsize,
   input  writeback_pkg::gpr_t      esp,
   output writeback_pkg::gpr_t      esp_next,
   output logic                     esp_en
);
   import writeback_pkg::*;

   gpr_t size_bytes;

   // byte count of the operand
   always_comb begin
      case (opsize)
         SIZE_BYTE: size_bytes = 32'd1;
         SIZE_WORD: size_bytes = 32'd2;
         default:   size_bytes = 32'd4;
      endcase
   end

   assign esp_en = wb_accept & (stack_op != STACK_NONE);

   always_comb begin
      // push grows down
      if (stack_op == STACK_PUSH) begin
         esp_next = esp - size_bytes;
      end else begin
         esp_next = esp + size_bytes;
      end
   end

   property p_legal_stack_size;
      @(posedge clk) disable iff (!rst_n)
         esp_en |-> size_is_legal(opsize);
   endproperty

   a_legal_stack_size : assert property (p_legal_stack_size)
      else $error("stack commit with illegal operand size %0d", opsize);

endmodule

// File: logic/wb_commit_ctrl.sv
`timescale 1ns/1ns

module wb_commit_ctrl (
   input  logic                      clk,
   input  logic                      rst_n,
   input  writeback_pkg::wb_bundle_t wb_in,
   input  logic                      wb_valid,
   input  writeback_pkg::dec_wb_t    dec_wb,
   input  logic                      wmem_ready,
   output logic                      wb_ready,
   output writeback_pkg::mem_wr_t    wmem,
   output logic                      wmem_valid,
   output logic                      wb_accept,
   output writeback_pkg::reg_wr_t    reg_wr_a,
   output writeback_pkg::reg_wr_t    reg_wr_b
);
   import writeback_pkg::*;

   logic is_xchg;
   logic xchg_to_mem;
   logic xchg_to_reg;
   logic mem_target;
   logic mem_stall;
   logic port_a_collision;

   // result classification
   assign is_xchg     = (wb_in.alu_op == ALU_OP_XCHG);
   assign xchg_to_mem = is_xchg & wb_in.op_b_is_address;
   assign xchg_to_reg = is_xchg & wb_in.op_b_is_reg;
   assign mem_target  = wb_in.op_a_is_address | xchg_to_mem;

   // memory write port
   always_comb begin
      if (xchg_to_mem) begin
         wmem.address = wb_in.op_b_address;
         // upper half zero-extended
         wmem.data    = {{(RESULT_W-GPR_W){1'b0}}, wb_in.result[RESULT_W-1:GPR_W]};
      end else begin
         wmem.address = wb_in.dest_address;
         wmem.data    = wb_in.result;
      end
      wmem.size = wb_in.opsize;
   end

   assign wmem_valid = wb_valid & mem_target;

   // back-pressure
   assign mem_stall        = mem_target & ~wmem_ready;
   // decode write owns the primary port this cycle
   assign port_a_collision = dec_wb.valid & wb_in.op_a_is_reg;

   assign wb_ready  = ~(mem_stall | port_a_collision);
   assign wb_accept = wb_valid & wb_ready;

   // primary port, decode write first
   always_comb begin
      if (dec_wb.valid) begin
         reg_wr_a.en   = 1'b1;
         reg_wr_a.num  = dec_wb.reg_num;
         reg_wr_a.size = dec_wb.size;
         reg_wr_a.data = dec_wb.data;
      end else begin
         reg_wr_a.en   = wb_accept & wb_in.op_a_is_reg;
         reg_wr_a.num  = wb_in.dest_reg;
         reg_wr_a.size = wb_in.opsize;
         reg_wr_a.data = wb_in.result[GPR_W-1:0];
      end
   end

   // second port, exchange into op_b
   always_comb begin
      reg_wr_b.en   = wb_accept & xchg_to_reg;
      reg_wr_b.num  = wb_in.op_b_reg;
      reg_wr_b.size = SIZE_DWORD;
      reg_wr_b.data = wb_in.result[RESULT_W-1:GPR_W];
   end

   // execute must hold the item until it is taken
   property p_hold_under_stall;
      @(posedge clk) disable iff (!rst_n)
         (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb_in));
   endproperty

   a_hold_under_stall : assert property (p_hold_under_stall)
      else $error("wb_in changed while stalled");

   // a stalled memory write keeps its address and data
   property p_wmem_stable;
      @(posedge clk) disable iff (!rst_n)
         (wmem_valid && !wmem_ready) |=> (wmem_valid && $stable(wmem));
   endproperty

   a_wmem_stable : assert property (p_wmem_stable)
      else $error("wmem changed before the memory took it");

endmodule

// File: logic/writeback_pkg.sv
package writeback_pkg;

   // widths
   localparam int ADDR_W    = 32;
   localparam int GPR_W     = 32;
   localparam int RESULT_W  = 64;
   localparam int REG_NUM_W = 3;
   localparam int ALU_OP_W  = 4;
   localparam int NUM_GPR   = 8;

   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [GPR_W-1:0]     gpr_t;
   typedef logic [RESULT_W-1:0]  result_t;
   typedef logic [REG_NUM_W-1:0] reg_num_t;
   typedef logic [ALU_OP_W-1:0]  alu_op_t;

   localparam alu_op_t  ALU_OP_XCHG = 4'd14;
   // eax ecx edx ebx esp ebp esi edi
   localparam reg_num_t REG_ESP     = 3'd4;

   // codes 3..7 are illegal
   typedef enum logic [2:0] {
      SIZE_BYTE  = 3'd0,
      SIZE_WORD  = 3'd1,
      SIZE_DWORD = 3'd2
   } op_size_t;

   typedef enum logic [1:0] {
      STACK_NONE = 2'd0,
      STACK_PUSH = 2'd1,
      STACK_POP  = 2'd2
   } stack_op_t;

   // execute result, high half of result is the exchange operand
   typedef struct packed {
      addr_t     dest_address;
      reg_num_t  dest_reg;
      result_t   result;
      op_size_t  opsize;
      alu_op_t   alu_op;
      logic      op_a_is_address;
      logic      op_a_is_reg;
      reg_num_t  op_b_reg;
      addr_t     op_b_address;
      logic      op_b_is_reg;
      logic      op_b_is_address;
      stack_op_t stack_op;
   } wb_bundle_t;

   // early register write from decode
   typedef struct packed {
      logic     valid;
      reg_num_t reg_num;
      op_size_t size;
      gpr_t     data;
   } dec_wb_t;

   typedef struct packed {
      logic     en;
      reg_num_t num;
      op_size_t size;
      gpr_t     data;
   } reg_wr_t;

   typedef struct packed {
      addr_t    address;
      result_t  data;
      op_size_t size;
   } mem_wr_t;

   typedef gpr_t [NUM_GPR-1:0] gpr_bank_t;

   function automatic logic size_is_legal(op_size_t size);
      return size inside {SIZE_BYTE, SIZE_WORD, SIZE_DWORD};
   endfunction

endpackage
